// File: hdl/dcache_data.sv
// --------------------------------------
// data cache array
// one word per address, always hits,
// byte-enable write from the store
// buffer, combinational load read
// --------------------------------------

`timescale 1ns/100ps

`include "stbuf_cfg.svh"

module dcache_data (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  stbuf_pkg::wr_req_t i_wr,
  input  stbuf_pkg::waddr_t  i_rd_waddr,
  output stbuf_pkg::data_t   o_rd_data
);

  // whole address space, no tags
  stbuf_pkg::data_t r_mem [`STBUF_WORDS];

  // --------------------------------------
  // write port
  // --------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      // array starts out all zero
      for (int w = 0; w < `STBUF_WORDS; w++) begin
        r_mem[w] <= '0;
      end
    end else if (i_wr.valid) begin
      // only strobed bytes change
      for (int b = 0; b < `STBUF_DATA_B; b++) begin
        if (i_wr.strb[b]) begin
          r_mem[i_wr.waddr][b*8 +: 8] <= i_wr.data[b*8 +: 8];
        end
      end
    end
  end

  // --------------------------------------
  // read port
  // --------------------------------------
  // contents before this edge's write,
  // fwd stage does the registering
  assign o_rd_data = r_mem[i_rd_waddr];

  // a drain always carries at least one byte
  a_wr_has_strb: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_wr.valid |-> (|i_wr.strb));

endmodule

// File: hdl/stbuf_cfg.svh
// --------------------------------------
// store buffer configuration
// sizes shared by the package and by
// every block of the store buffer
// --------------------------------------

`ifndef STBUF_CFG_SVH
`define STBUF_CFG_SVH

// number of buffer entries, 2 to 8
`define STBUF_ENTRIES 4

// byte address width, 128 byte space
`define STBUF_PADDR_W 7

// bytes per data word and offset bits
`define STBUF_DATA_B  8
`define STBUF_OFFS_W  3

// cache words covering the whole space
`define STBUF_WORDS   ((1 << `STBUF_PADDR_W) / `STBUF_DATA_B)

`endif

// File: hdl/stbuf_ctrl.sv
// --------------------------------------
// store buffer control
// in / out pointers, alloc / merge / full
// decision, in-order drain to the cache
// and the entry age matrix
// --------------------------------------

`timescale 1ns/100ps

`include "stbuf_cfg.svh"

module stbuf_ctrl (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  stbuf_pkg::st_req_t      i_st,
  input  logic                    i_drain_en,
  input  stbuf_pkg::entry_t       i_entries [`STBUF_ENTRIES],
  input  stbuf_pkg::entry_state_e i_states [`STBUF_ENTRIES],
  output stbuf_pkg::eidx_oh_t     o_load_oh,
  output stbuf_pkg::eidx_oh_t     o_merge_oh,
  output stbuf_pkg::eidx_oh_t     o_drain_oh,
  output stbuf_pkg::eidx_oh_t     o_age_oh [`STBUF_ENTRIES],
  output stbuf_pkg::wr_req_t      o_wr,
  output stbuf_pkg::st_resp_e     o_st_resp
);

  stbuf_pkg::eidx_oh_t r_in_ptr;
  stbuf_pkg::eidx_oh_t r_out_ptr;
  // r_age[i][j] set when entry j is older than i
  stbuf_pkg::eidx_oh_t r_age [`STBUF_ENTRIES];

  stbuf_pkg::eidx_oh_t w_valid;
  stbuf_pkg::eidx_oh_t w_wait;
  stbuf_pkg::eidx_oh_t w_match;
  stbuf_pkg::eidx_oh_t w_merge_sel;
  stbuf_pkg::entry_t   w_head;
  logic                w_full;
  logic                w_alloc;
  logic                w_drain;

  // --------------------------------------
  // merge search, youngest match wins
  // --------------------------------------
  always_comb begin
    for (int i = 0; i < `STBUF_ENTRIES; i++) begin
      w_valid[i] = i_entries[i].valid;
      w_wait[i]  = (i_states[i] == stbuf_pkg::E_WAIT);
      // head is off limits while it drains this edge
      w_match[i] = i_st.valid & w_wait[i] & (i_entries[i].waddr == i_st.waddr) &
                   ~(r_out_ptr[i] & i_drain_en);
    end
    for (int j = 0; j < `STBUF_ENTRIES; j++) begin
      w_merge_sel[j] = w_match[j];
      for (int k = 0; k < `STBUF_ENTRIES; k++) begin
        if (w_match[k] && r_age[k][j]) begin
          w_merge_sel[j] = 1'b0;
        end
      end
    end
  end

  // full when the slot at the in pointer is still busy
  assign w_full  = |(r_in_ptr & w_valid);
  assign w_alloc = i_st.valid & ~(|w_match) & ~w_full;
  assign w_drain = |(r_out_ptr & w_wait) & i_drain_en;

  assign o_load_oh  = r_in_ptr & {`STBUF_ENTRIES{w_alloc}};
  assign o_merge_oh = w_merge_sel;
  assign o_drain_oh = r_out_ptr & {`STBUF_ENTRIES{w_drain}};
  assign o_age_oh   = r_age;

  always_comb begin
    if (|w_match) begin
      o_st_resp = stbuf_pkg::ST_MERGE;
    end else if (!w_full) begin
      o_st_resp = stbuf_pkg::ST_ALLOC;
    end else begin
      o_st_resp = stbuf_pkg::ST_FULL;
    end
  end

  // --------------------------------------
  // head entry to cache write
  // --------------------------------------
  always_comb begin
    w_head = '0;
    for (int i = 0; i < `STBUF_ENTRIES; i++) begin
      if (r_out_ptr[i]) begin
        w_head = i_entries[i];
      end
    end
    o_wr.valid = w_drain;
    o_wr.waddr = w_head.waddr;
    o_wr.strb  = w_head.strb;
    o_wr.data  = w_head.data;
  end

  // --------------------------------------
  // pointers and age order
  // --------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr  <= stbuf_pkg::eidx_oh_t'(1);
      r_out_ptr <= stbuf_pkg::eidx_oh_t'(1);
      for (int i = 0; i < `STBUF_ENTRIES; i++) begin
        r_age[i] <= '0;
      end
    end else begin
      if (w_alloc) begin
        r_in_ptr <= {r_in_ptr[`STBUF_ENTRIES-2:0], r_in_ptr[`STBUF_ENTRIES-1]};
      end
      if (w_drain) begin
        r_out_ptr <= {r_out_ptr[`STBUF_ENTRIES-2:0], r_out_ptr[`STBUF_ENTRIES-1]};
      end
      for (int i = 0; i < `STBUF_ENTRIES; i++) begin
        if (o_load_oh[i]) begin
          // everything occupied now is older
          r_age[i] <= w_valid;
        end else if (w_alloc) begin
          // new entry is younger than all others
          r_age[i] <= r_age[i] & ~r_in_ptr;
        end
      end
    end
  end

  // waiting entries start at the out pointer
  a_head_waits: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (|w_wait) |-> (|(r_out_ptr & w_wait)));

  // age order picks at most one merge target
  a_merge_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(o_merge_oh));

endmodule

// File: hdl/stbuf_entry.sv
// --------------------------------------
// store buffer entry
// holds one committed store word, takes
// merges while waiting and steps through
// the drain sequence
// --------------------------------------

`timescale 1ns/100ps

`include "stbuf_cfg.svh"

module stbuf_entry (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_load,
  input  logic                    i_merge,
  input  logic                    i_drain,
  input  stbuf_pkg::st_req_t      i_st,
  output stbuf_pkg::entry_t       o_entry,
  output stbuf_pkg::entry_state_e o_state
);

  stbuf_pkg::entry_state_e r_state;
  stbuf_pkg::entry_state_e w_state_nxt;

  // payload, no reset
  stbuf_pkg::waddr_t       r_waddr;
  stbuf_pkg::strb_t        r_strb;
  stbuf_pkg::data_t        r_data;

  // --------------------------------------
  // state machine
  // --------------------------------------
  always_comb begin
    w_state_nxt = r_state;
    case (r_state)
      // free slot, waits for an allocation
      stbuf_pkg::E_EMPTY: begin
        if (i_load) begin
          w_state_nxt = stbuf_pkg::E_WAIT;
        end
      end
      // pending, mergeable until drained
      stbuf_pkg::E_WAIT: begin
        if (i_drain) begin
          w_state_nxt = stbuf_pkg::E_DRAIN;
        end
      end
      // word written last edge, one cycle hold
      stbuf_pkg::E_DRAIN: begin
        w_state_nxt = stbuf_pkg::E_EMPTY;
      end
      default: begin
        w_state_nxt = stbuf_pkg::E_EMPTY;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= stbuf_pkg::E_EMPTY;
    end else begin
      r_state <= w_state_nxt;
    end
  end

  // --------------------------------------
  // payload capture and byte merge
  // --------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_waddr <= i_st.waddr;
      r_strb  <= i_st.strb;
      r_data  <= i_st.data;
    end else if (i_merge) begin
      // newer bytes win, strobes accumulate
      r_strb <= r_strb | i_st.strb;
      for (int b = 0; b < `STBUF_DATA_B; b++) begin
        if (i_st.strb[b]) begin
          r_data[b*8 +: 8] <= i_st.data[b*8 +: 8];
        end
      end
    end
  end

  // draining slot still counts as occupied
  assign o_entry.valid = (r_state != stbuf_pkg::E_EMPTY);
  assign o_entry.waddr = r_waddr;
  assign o_entry.strb  = r_strb;
  assign o_entry.data  = r_data;
  assign o_state       = r_state;

  // ctrl must only merge into a waiting word
  a_merge_in_wait: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_merge |-> (r_state == stbuf_pkg::E_WAIT));

endmodule

// File: hdl/stbuf_fwd.sv
// --------------------------------------
// store to load forwarding
// overlays pending store bytes on the
// cache read word, youngest byte first,
// result registered one cycle later
// --------------------------------------

`timescale 1ns/100ps

`include "stbuf_cfg.svh"

module stbuf_fwd (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_ld_valid,
  input  stbuf_pkg::paddr_t   i_ld_paddr,
  input  stbuf_pkg::entry_t   i_entries [`STBUF_ENTRIES],
  input  stbuf_pkg::eidx_oh_t i_age_oh [`STBUF_ENTRIES],
  input  stbuf_pkg::data_t    i_rd_data,
  output logic                o_ld_valid,
  output stbuf_pkg::data_t    o_ld_data,
  output stbuf_pkg::strb_t    o_ld_strb_fwd
);

  stbuf_pkg::waddr_t   w_ld_waddr;
  stbuf_pkg::eidx_oh_t w_match;
  stbuf_pkg::data_t    w_fwd_data;
  stbuf_pkg::strb_t    w_fwd_strb;
  logic                r_ld_valid;
  stbuf_pkg::data_t    r_ld_data;
  stbuf_pkg::strb_t    r_ld_strb;

  assign w_ld_waddr = i_ld_paddr[`STBUF_PADDR_W-1:`STBUF_OFFS_W];

  // occupied entries holding the load word
  always_comb begin
    for (int j = 0; j < `STBUF_ENTRIES; j++) begin
      w_match[j] = i_entries[j].valid & (i_entries[j].waddr == w_ld_waddr);
    end
  end

  // --------------------------------------
  // per byte youngest-hit select
  // --------------------------------------
  for (genvar b = 0; b < `STBUF_DATA_B; b++) begin : g_byte
    stbuf_pkg::eidx_oh_t w_hit;
    stbuf_pkg::eidx_oh_t w_sel;
    logic [7:0]          w_byte;

    always_comb begin
      for (int j = 0; j < `STBUF_ENTRIES; j++) begin
        w_hit[j] = w_match[j] & i_entries[j].strb[b];
      end
      // cache byte unless some store covers it
      w_byte = i_rd_data[b*8 +: 8];
      for (int j = 0; j < `STBUF_ENTRIES; j++) begin
        w_sel[j] = w_hit[j];
        for (int k = 0; k < `STBUF_ENTRIES; k++) begin
          // a younger hit k hides entry j
          if (w_hit[k] && i_age_oh[k][j]) begin
            w_sel[j] = 1'b0;
          end
        end
        if (w_sel[j]) begin
          w_byte = i_entries[j].data[b*8 +: 8];
        end
      end
    end

    assign w_fwd_data[b*8 +: 8] = w_byte;
    assign w_fwd_strb[b]        = |w_hit;
  end

  // --------------------------------------
  // load result register
  // --------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ld_valid <= 1'b0;
    end else begin
      r_ld_valid <= i_ld_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ld_valid) begin
      r_ld_data <= w_fwd_data;
      r_ld_strb <= w_fwd_strb;
    end
  end

  assign o_ld_valid    = r_ld_valid;
  assign o_ld_data     = r_ld_data;
  assign o_ld_strb_fwd = r_ld_strb;

endmodule

// File: hdl/stbuf_pkg.sv
// --------------------------------------
// store buffer types
// address, data and strobe vectors, the
// store response and entry state enums
// and the request / entry / write views
// --------------------------------------

`include "stbuf_cfg.svh"

package stbuf_pkg;

  // --------------------------------------
  // plain vectors
  // --------------------------------------
  typedef logic [`STBUF_PADDR_W-1:0]               paddr_t;
  // word address, byte offset stripped
  typedef logic [`STBUF_PADDR_W-`STBUF_OFFS_W-1:0] waddr_t;
  typedef logic [`STBUF_DATA_B*8-1:0]              data_t;
  typedef logic [`STBUF_DATA_B-1:0]                strb_t;
  // one bit per buffer entry
  typedef logic [`STBUF_ENTRIES-1:0]               eidx_oh_t;

  // --------------------------------------
  // enums
  // --------------------------------------
  typedef enum logic [1:0] {ST_ALLOC, ST_MERGE, ST_FULL} st_resp_e;

  typedef enum logic [1:0] {E_EMPTY, E_WAIT, E_DRAIN} entry_state_e;

  // --------------------------------------
  // bundles
  // --------------------------------------
  // committed store from the lsu
  typedef struct packed {
    logic   valid;
    waddr_t waddr;
    strb_t  strb;
    data_t  data;
  } st_req_t;

  // entry contents as seen by ctrl and fwd
  typedef struct packed {
    logic   valid;
    waddr_t waddr;
    strb_t  strb;
    data_t  data;
  } entry_t;

  // byte-enable write into the data array
  typedef struct packed {
    logic   valid;
    waddr_t waddr;
    strb_t  strb;
    data_t  data;
  } wr_req_t;

endpackage

// File: hdl/stbuf_top.sv
// --------------------------------------
// store buffer top
// control, entries, load forwarding and
// the data array of the load/store unit
// --------------------------------------

`timescale 1ns/100ps

`include "stbuf_cfg.svh"

module stbuf_top (
  input  logic                i_clk,
  input  logic                i_reset_n,
  // committed store port
  input  stbuf_pkg::st_req_t  i_st,
  output stbuf_pkg::st_resp_e o_st_resp,
  // cache write grant
  input  logic                i_drain_en,
  // load port
  input  logic                i_ld_valid,
  input  stbuf_pkg::paddr_t   i_ld_paddr,
  output logic                o_ld_valid,
  output stbuf_pkg::data_t    o_ld_data,
  output stbuf_pkg::strb_t    o_ld_strb_fwd
);

  stbuf_pkg::entry_t       w_entries [`STBUF_ENTRIES];
  stbuf_pkg::entry_state_e w_states [`STBUF_ENTRIES];
  stbuf_pkg::eidx_oh_t     w_age_oh [`STBUF_ENTRIES];
  stbuf_pkg::eidx_oh_t     w_load_oh;
  stbuf_pkg::eidx_oh_t     w_merge_oh;
  stbuf_pkg::eidx_oh_t     w_drain_oh;
  stbuf_pkg::wr_req_t      w_wr;
  stbuf_pkg::waddr_t       w_ld_waddr;
  stbuf_pkg::data_t        w_rd_data;

  // --------------------------------------
  // control
  // --------------------------------------
  stbuf_ctrl u_ctrl (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_st       (i_st),
    .i_drain_en (i_drain_en),
    .i_entries  (w_entries),
    .i_states   (w_states),
    .o_load_oh  (w_load_oh),
    .o_merge_oh (w_merge_oh),
    .o_drain_oh (w_drain_oh),
    .o_age_oh   (w_age_oh),
    .o_wr       (w_wr),
    .o_st_resp  (o_st_resp)
  );

  // --------------------------------------
  // entries
  // --------------------------------------
  for (genvar e = 0; e < `STBUF_ENTRIES; e++) begin : g_entry
    stbuf_entry u_entry (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_load    (w_load_oh[e]),
      .i_merge   (w_merge_oh[e]),
      .i_drain   (w_drain_oh[e]),
      .i_st      (i_st),
      .o_entry   (w_entries[e]),
      .o_state   (w_states[e])
    );
  end

  // --------------------------------------
  // load path
  // --------------------------------------
  assign w_ld_waddr = i_ld_paddr[`STBUF_PADDR_W-1:`STBUF_OFFS_W];

  dcache_data u_dcache (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_wr       (w_wr),
    .i_rd_waddr (w_ld_waddr),
    .o_rd_data  (w_rd_data)
  );

  stbuf_fwd u_fwd (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_ld_valid    (i_ld_valid),
    .i_ld_paddr    (i_ld_paddr),
    .i_entries     (w_entries),
    .i_age_oh      (w_age_oh),
    .i_rd_data     (w_rd_data),
    .o_ld_valid    (o_ld_valid),
    .o_ld_data     (o_ld_data),
    .o_ld_strb_fwd (o_ld_strb_fwd)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# build the store buffer testbench with verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_stbuf \
  && ./obj_dir/Vtb_stbuf > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log \
  && { echo "result: failing"; exit 1; } \
  || { echo "result: clean"; exit 0; }

// File: sim/tb_stbuf.sv
// --------------------------------------
// store buffer testbench
// directed and random stores, drains and
// loads against a byte-level cache model
// plus an age-ordered entry queue
// --------------------------------------

`timescale 1ns/100ps

`include "stbuf_cfg.svh"

module tb_stbuf;

  localparam int N            = `STBUF_ENTRIES;
  localparam int WORDS        = `STBUF_WORDS;
  localparam int DATA_B       = `STBUF_DATA_B;
  localparam int RESET_CYCLES = 10;
  localparam int RAND_CYCLES  = 400;
  // directed tests stay well below this
  localparam int TEST_CYCLES  = RAND_CYCLES + 150;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + TEST_CYCLES) * 10 + 1000;

  logic                i_clk;
  logic                i_reset_n;
  stbuf_pkg::st_req_t  i_st;
  stbuf_pkg::st_resp_e o_st_resp;
  logic                i_drain_en;
  logic                i_ld_valid;
  stbuf_pkg::paddr_t   i_ld_paddr;
  logic                o_ld_valid;
  stbuf_pkg::data_t    o_ld_data;
  stbuf_pkg::strb_t    o_ld_strb_fwd;

  integer seed;
  int     err_count;
  int     check_count;
  int     tests_run;
  int     test_err_base;

  // --------------------------------------
  // reference model
  // --------------------------------------
  logic [7:0]        m_cache [1 << `STBUF_PADDR_W];
  // oldest entry first
  stbuf_pkg::waddr_t q_waddr [$];
  stbuf_pkg::strb_t  q_strb [$];
  stbuf_pkg::data_t  q_data [$];
  bit                q_drn [$];

  // load issued last cycle, due now
  logic              exp_ld_valid;
  stbuf_pkg::data_t  exp_ld_data;
  stbuf_pkg::strb_t  exp_ld_strb;

  stbuf_top uut (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_st          (i_st),
    .o_st_resp     (o_st_resp),
    .i_drain_en    (i_drain_en),
    .i_ld_valid    (i_ld_valid),
    .i_ld_paddr    (i_ld_paddr),
    .o_ld_valid    (o_ld_valid),
    .o_ld_data     (o_ld_data),
    .o_ld_strb_fwd (o_ld_strb_fwd)
  );

  initial i_clk = 1'b0;
  always #5 i_clk = ~i_clk;

  function automatic void report_error(input string msg);
    $display("CHECK FAILED t=%0t: %s", $time, msg);
    err_count++;
  endfunction

  function automatic stbuf_pkg::st_req_t make_store(input logic valid,
      input stbuf_pkg::waddr_t waddr, input stbuf_pkg::strb_t strb,
      input stbuf_pkg::data_t data);
    stbuf_pkg::st_req_t st;
    st.valid = valid;
    st.waddr = waddr;
    st.strb  = strb;
    st.data  = data;
    return st;
  endfunction

  function automatic stbuf_pkg::strb_t rand_strb();
    stbuf_pkg::strb_t s;
    s = stbuf_pkg::strb_t'($random(seed));
    // a store always writes at least one byte
    if (s == '0) begin
      s = 8'h01;
    end
    return s;
  endfunction

  function automatic stbuf_pkg::data_t rand_data();
    stbuf_pkg::data_t d;
    d[31:0]  = $random(seed);
    d[63:32] = $random(seed);
    return d;
  endfunction

  function automatic stbuf_pkg::paddr_t byte_addr(input stbuf_pkg::waddr_t w, input int b);
    return stbuf_pkg::paddr_t'(int'(w) * DATA_B + b);
  endfunction

  // first entry not yet draining, -1 if none
  function automatic int find_head();
    for (int i = 0; i < q_waddr.size(); i++) begin
      if (!q_drn[i]) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic void predict_store(input stbuf_pkg::st_req_t st, input logic drain_en,
      output stbuf_pkg::st_resp_e resp, output int merge_idx);
    int head;
    head      = find_head();
    merge_idx = -1;
    // youngest waiting match, head excluded while it drains
    for (int i = 0; i < q_waddr.size(); i++) begin
      if (!q_drn[i] && (q_waddr[i] == st.waddr) && !((i == head) && drain_en)) begin
        merge_idx = i;
      end
    end
    if (merge_idx >= 0) begin
      resp = stbuf_pkg::ST_MERGE;
    end else if (q_waddr.size() < N) begin
      resp = stbuf_pkg::ST_ALLOC;
    end else begin
      resp = stbuf_pkg::ST_FULL;
    end
  endfunction

  function automatic void predict_load(input stbuf_pkg::paddr_t paddr,
      output stbuf_pkg::data_t data, output stbuf_pkg::strb_t strb);
    stbuf_pkg::waddr_t w;
    w    = stbuf_pkg::waddr_t'(paddr >> `STBUF_OFFS_W);
    strb = '0;
    for (int b = 0; b < DATA_B; b++) begin
      data[b*8 +: 8] = m_cache[int'(w) * DATA_B + b];
    end
    // walk oldest to youngest, later bytes win
    for (int i = 0; i < q_waddr.size(); i++) begin
      if (q_waddr[i] == w) begin
        for (int b = 0; b < DATA_B; b++) begin
          if (q_strb[i][b]) begin
            data[b*8 +: 8] = q_data[i][b*8 +: 8];
            strb[b]        = 1'b1;
          end
        end
      end
    end
  endfunction

  // model state change at the clock edge
  function automatic void apply_edge(input stbuf_pkg::st_req_t st, input logic drain_en);
    stbuf_pkg::st_resp_e resp;
    stbuf_pkg::data_t    d;
    int                  merge_idx;
    int                  head;
    int                  n_old;
    predict_store(st, drain_en, resp, merge_idx);
    head  = find_head();
    n_old = 0;
    for (int i = 0; i < q_drn.size(); i++) begin
      if (q_drn[i]) begin
        n_old++;
      end
    end
    if ((head >= 0) && drain_en) begin
      for (int b = 0; b < DATA_B; b++) begin
        if (q_strb[head][b]) begin
          m_cache[int'(q_waddr[head]) * DATA_B + b] = q_data[head][b*8 +: 8];
        end
      end
      q_drn[head] = 1'b1;
    end
    if (st.valid && (resp == stbuf_pkg::ST_MERGE)) begin
      d = q_data[merge_idx];
      for (int b = 0; b < DATA_B; b++) begin
        if (st.strb[b]) begin
          d[b*8 +: 8] = st.data[b*8 +: 8];
        end
      end
      q_data[merge_idx] = d;
      q_strb[merge_idx] = q_strb[merge_idx] | st.strb;
    end
    // entries drained one edge ago leave now
    repeat (n_old) begin
      void'(q_waddr.pop_front());
      void'(q_strb.pop_front());
      void'(q_data.pop_front());
      void'(q_drn.pop_front());
    end
    if (st.valid && (resp == stbuf_pkg::ST_ALLOC)) begin
      q_waddr.push_back(st.waddr);
      q_strb.push_back(st.strb);
      q_data.push_back(st.data);
      q_drn.push_back(1'b0);
    end
  endfunction

  // --------------------------------------
  // one bus cycle: drive, check, update
  // --------------------------------------
  task automatic cycle_step(input stbuf_pkg::st_req_t st, input logic drain_en,
      input logic ld_valid, input stbuf_pkg::paddr_t ld_paddr);
    stbuf_pkg::st_resp_e resp;
    stbuf_pkg::data_t    ld_data;
    stbuf_pkg::strb_t    ld_strb;
    int                  merge_idx;
    @(posedge i_clk);
    i_st       <= st;
    i_drain_en <= drain_en;
    i_ld_valid <= ld_valid;
    i_ld_paddr <= ld_paddr;
    @(negedge i_clk);
    check_count++;
    if (o_ld_valid !== exp_ld_valid) begin
      report_error($sformatf("o_ld_valid %b, expected %b", o_ld_valid, exp_ld_valid));
    end else if (exp_ld_valid) begin
      check_count++;
      if ((o_ld_data !== exp_ld_data) || (o_ld_strb_fwd !== exp_ld_strb)) begin
        report_error($sformatf("load data %h strb %b, expected %h strb %b",
                               o_ld_data, o_ld_strb_fwd, exp_ld_data, exp_ld_strb));
      end
    end
    if (st.valid) begin
      predict_store(st, drain_en, resp, merge_idx);
      check_count++;
      if (o_st_resp !== resp) begin
        report_error($sformatf("store to word %0d got %s, expected %s",
                               st.waddr, o_st_resp.name(), resp.name()));
      end
    end
    exp_ld_valid = ld_valid;
    if (ld_valid) begin
      predict_load(ld_paddr, ld_data, ld_strb);
      exp_ld_data = ld_data;
      exp_ld_strb = ld_strb;
    end
    apply_edge(st, drain_en);
  endtask

  task automatic drain_all();
    int guard;
    guard = 0;
    while ((q_waddr.size() != 0) && (guard < 4 * N)) begin
      cycle_step('0, 1'b1, 1'b0, '0);
      guard++;
    end
    if (q_waddr.size() != 0) begin
      $display("drain with the grant held high did not empty the buffer in %0d cycles", 4 * N);
      err_count++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %-12s done, %0d errors", name, err_count - test_err_base);
    tests_run++;
    test_err_base = err_count;
  endtask

  // --------------------------------------
  // watchdog
  // --------------------------------------
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the tests did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

  // --------------------------------------
  // test sequence
  // --------------------------------------
  initial begin
    stbuf_pkg::waddr_t base;
    stbuf_pkg::waddr_t w;
    seed          = 32'h71df6899;
    err_count     = 0;
    check_count   = 0;
    tests_run     = 0;
    test_err_base = 0;
    exp_ld_valid  = 1'b0;
    exp_ld_data   = '0;
    exp_ld_strb   = '0;
    for (int a = 0; a < (1 << `STBUF_PADDR_W); a++) begin
      m_cache[a] = 8'h00;
    end
    i_reset_n  = 1'b0;
    i_st       = '0;
    i_drain_en = 1'b0;
    i_ld_valid = 1'b0;
    i_ld_paddr = '0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_reset_n <= 1'b1;

    // zero cache, one-cycle load latency with gaps
    for (int k = 0; k < 16; k++) begin
      cycle_step('0, 1'b0, (k % 3) != 2, stbuf_pkg::paddr_t'($random(seed)));
    end
    cycle_step('0, 1'b0, 1'b0, '0);
    finish_test("reset_loads");

    // distinct words, no grant: alloc then full
    base = stbuf_pkg::waddr_t'($random(seed));
    for (int k = 0; k < N + 2; k++) begin
      cycle_step(make_store(1'b1, base + stbuf_pkg::waddr_t'(k), rand_strb(), rand_data()),
                 1'b0, 1'b0, '0);
    end
    for (int k = 0; k < N + 2; k++) begin
      cycle_step('0, 1'b0, 1'b1, byte_addr(base + stbuf_pkg::waddr_t'(k), k % DATA_B));
    end
    cycle_step('0, 1'b0, 1'b0, '0);
    finish_test("fill_full");

    // merges into a waiting word
    w = base + 1;
    cycle_step(make_store(1'b1, w, 8'hf0, rand_data()), 1'b0, 1'b0, '0);
    cycle_step(make_store(1'b1, w, 8'h0f, rand_data()), 1'b0, 1'b1, byte_addr(w, 0));
    cycle_step('0, 1'b0, 1'b1, byte_addr(w, 4));
    cycle_step('0, 1'b0, 1'b0, '0);
    finish_test("merge");

    // same word twice: head drains, younger copy wins
    drain_all();
    w = stbuf_pkg::waddr_t'($random(seed));
    cycle_step(make_store(1'b1, w, 8'h0f, rand_data()), 1'b0, 1'b0, '0);
    cycle_step(make_store(1'b1, w + 1, 8'hff, rand_data()), 1'b0, 1'b0, '0);
    cycle_step(make_store(1'b1, w, 8'h3c, rand_data()), 1'b1, 1'b1, byte_addr(w, 0));
    cycle_step(make_store(1'b1, w, 8'hc0, rand_data()), 1'b0, 1'b1, byte_addr(w, 2));
    cycle_step('0, 1'b0, 1'b1, byte_addr(w, 5));
    cycle_step('0, 1'b0, 1'b0, '0);
    finish_test("youngest");

    // random traffic on a few hot words
    for (int k = 0; k < RAND_CYCLES; k++) begin
      cycle_step(make_store(($random(seed) & 3) != 0, stbuf_pkg::waddr_t'($random(seed) & 7),
                            rand_strb(), rand_data()),
                 1'($random(seed)), 1'($random(seed)),
                 stbuf_pkg::paddr_t'($random(seed) & 8'h3f));
    end
    drain_all();
    for (int k = 0; k < WORDS; k++) begin
      cycle_step('0, 1'b1, 1'b1, byte_addr(stbuf_pkg::waddr_t'(k), 0));
    end
    cycle_step('0, 1'b1, 1'b0, '0);
    finish_test("random");

    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, check_count, err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+hdl
hdl/stbuf_pkg.sv
hdl/stbuf_entry.sv
hdl/stbuf_ctrl.sv
hdl/stbuf_fwd.sv
hdl/dcache_data.sv
hdl/stbuf_top.sv
sim/tb_stbuf.sv
